/* Bender.yml */
package:
  name: pageTableWalker

sources:
  - files:
      - logic/ptwPkg.sv
      - logic/missArbiter.sv
      - logic/walkerFsm.sv
      - logic/pteDecode.sv
      - logic/ptAddrGen.sv
      - logic/pageTableWalker.sv
  - target: simulation
    files:
      - sim/tbPageTableWalker.sv

/* logic/missArbiter.sv */
////////////////////////////////////////////////////////////////////////////
// TLB miss arbiter
// Grants the single walk port to a data miss ahead of an instruction miss
// and freezes the winning request for the length of the walk
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module missArbiter (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    itlbMiss,
  input  logic                    dtlbMiss,
  input  logic                    memStore,
  input  logic [ptwPkg::xlen-1:0] pc,
  input  logic [ptwPkg::xlen-1:0] memAdr,
  input  logic                    walkStart,
  output logic                    walkReq,
  output logic [ptwPkg::xlen-1:0] walkVAdr,
  output logic                    walkIsData,
  output logic                    walkIsStore
);

  // Either requester may start a walk
  assign walkReq = itlbMiss | dtlbMiss;

  // The address is plain payload and only moves on a granted walk
  always_ff @(posedge clk) begin
    if (walkStart) begin
      walkVAdr <= dtlbMiss ? memAdr : pc;
    end
  end

  // Requester and access kind, data wins a simultaneous miss
  always_ff @(posedge clk) begin
    if (!rstN) begin
      walkIsData  <= 1'b0;
      walkIsStore <= 1'b0;
    end else if (walkStart) begin
      walkIsData  <= dtlbMiss;
      // An instruction fetch is never a store
      walkIsStore <= dtlbMiss & memStore;
    end
  end

  // The walker must never launch a walk that nobody asked for
  startNeedsRequest: assert property (@(posedge clk) disable iff (!rstN)
    walkStart |-> walkReq);

endmodule

`default_nettype wire

/* logic/pageTableWalker.sv */
////////////////////////////////////////////////////////////////////////////
// Sv39 hardware page table walker
// Serves instruction and data TLB misses over one page table read port,
// returning a TLB entry or a page fault at the end of each walk
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module pageTableWalker #(
  parameter int paBits = 56
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [ptwPkg::xlen-1:0] satp,
  // Miss requests from the two TLBs
  input  logic                    itlbMiss,
  input  logic [ptwPkg::xlen-1:0] pc,
  input  logic                    dtlbMiss,
  input  logic [ptwPkg::xlen-1:0] memAdr,
  input  logic                    memStore,
  // Page table read port
  input  logic [ptwPkg::xlen-1:0] memPte,
  input  logic                    memStall,
  output logic [paBits-1:0]       memPAdr,
  output logic                    memRead,
  // Results to the TLBs and the core
  output logic [ptwPkg::xlen-1:0] pageTableEntry,
  output ptwPkg::pageType_t       pageType,
  output logic                    itlbWrite,
  output logic                    dtlbWrite,
  output logic                    instrPageFault,
  output logic                    loadPageFault,
  output logic                    storePageFault,
  output logic                    mmuStall
);

  logic                       walkReq, walkStart, walkIsData, walkIsStore;
  logic [ptwPkg::xlen-1:0]    walkVAdr, pte;
  logic [ptwPkg::ppnBits-1:0] curPpn;
  logic                       pteEn, useRoot, pteValid, pteLeaf, pteBad;
  ptwPkg::level_t             level;

  missArbiter arbiter (
    .clk(clk), .rstN(rstN), .itlbMiss(itlbMiss), .dtlbMiss(dtlbMiss),
    .memStore(memStore), .pc(pc), .memAdr(memAdr), .walkStart(walkStart),
    .walkReq(walkReq), .walkVAdr(walkVAdr), .walkIsData(walkIsData),
    .walkIsStore(walkIsStore)
  );

  walkerFsm fsm (
    .clk(clk), .rstN(rstN), .walkReq(walkReq), .walkIsData(walkIsData),
    .walkIsStore(walkIsStore), .pteValid(pteValid), .pteLeaf(pteLeaf),
    .pteBad(pteBad), .pageTableEntryIn(pte), .memStall(memStall),
    .walkStart(walkStart), .pteEn(pteEn), .memRead(memRead), .useRoot(useRoot),
    .level(level), .pageTableEntry(pageTableEntry), .pageType(pageType),
    .itlbWrite(itlbWrite), .dtlbWrite(dtlbWrite), .instrPageFault(instrPageFault),
    .loadPageFault(loadPageFault), .storePageFault(storePageFault), .mmuStall(mmuStall)
  );

  pteDecode decode (
    .clk(clk), .rstN(rstN), .pteEn(pteEn), .memPte(memPte), .level(level),
    .walkIsStore(walkIsStore), .pte(pte), .curPpn(curPpn), .pteValid(pteValid),
    .pteLeaf(pteLeaf), .pteBad(pteBad)
  );

  ptAddrGen #(.paBits(paBits)) addrGen (
    .satp(satp), .curPpn(curPpn), .walkVAdr(walkVAdr), .level(level),
    .useRoot(useRoot), .memPAdr(memPAdr)
  );

  // Memory may rely on the address staying put across a stalled read
  addrHeldInStall: assert property (@(posedge clk) disable iff (!rstN)
    (memRead && memStall) |=> $stable(memPAdr));

endmodule

`default_nettype wire

/* logic/ptAddrGen.sv */
////////////////////////////////////////////////////////////////////////////
// PTE address generator
// Joins the root or current PPN with the VPN slice of the level to form
// the physical address of the next PTE
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ptAddrGen #(
  parameter int paBits = 56
) (
  input  logic [ptwPkg::xlen-1:0]    satp,
  input  logic [ptwPkg::ppnBits-1:0] curPpn,
  input  logic [ptwPkg::xlen-1:0]    walkVAdr,
  input  ptwPkg::level_t             level,
  input  logic                       useRoot,
  output logic [paBits-1:0]          memPAdr
);

  // Full width of a PTE address before truncation
  localparam int fullBits = ptwPkg::ppnBits + ptwPkg::vpnBits + ptwPkg::pteBytesLog;

  logic [ptwPkg::vpnBits-1:0] vpn;
  logic [ptwPkg::ppnBits-1:0] basePpn;
  logic [fullBits-1:0]        fullAdr;

  // VPN[2] sits at 38:30, VPN[1] at 29:21 and VPN[0] at 20:12
  always_comb begin
    case (level)
      2'd2:    vpn = walkVAdr[ptwPkg::pageOffsetBits+2*ptwPkg::vpnBits +: ptwPkg::vpnBits];
      2'd1:    vpn = walkVAdr[ptwPkg::pageOffsetBits+ptwPkg::vpnBits +: ptwPkg::vpnBits];
      default: vpn = walkVAdr[ptwPkg::pageOffsetBits +: ptwPkg::vpnBits];
    endcase
  end

  // Only the root level reads the table named by satp
  assign basePpn = useRoot ? satp[ptwPkg::ppnBits-1:0] : curPpn;

  assign fullAdr = {basePpn, vpn, {ptwPkg::pteBytesLog{1'b0}}};

  // A narrower physical space simply drops the upper address bits
  assign memPAdr = fullAdr[paBits-1:0];

endmodule

`default_nettype wire

/* logic/pteDecode.sv */
////////////////////////////////////////////////////////////////////////////
// PTE capture and decode
// Registers each PTE returned by memory and judges it for validity,
// leaf status, superpage alignment and the accessed/dirty alert
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module pteDecode (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       pteEn,
  input  logic [ptwPkg::xlen-1:0]    memPte,
  input  ptwPkg::level_t             level,
  input  logic                       walkIsStore,
  output logic [ptwPkg::xlen-1:0]    pte,
  output logic [ptwPkg::ppnBits-1:0] curPpn,
  output logic                       pteValid,
  output logic                       pteLeaf,
  output logic                       pteBad
);

  // Permission and status bits that the walk needs from the low byte
  logic dirty, accessed;
  logic executable, writable, readable, valid;
  logic accessAlert;
  logic misaligned;

  // The last fetched entry is judged in the level state that follows the wait
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pte <= '0;
    end else if (pteEn) begin
      pte <= memPte;
    end
  end

  // Global and user in bits 5:4 only matter to the TLB
  assign {dirty, accessed} = pte[7:6];
  assign {executable, writable, readable, valid} = pte[3:0];

  // PPN sits just above the two RSW bits
  assign curPpn = pte[ptwPkg::ppnBits+9:10];

  // Write without read is a reserved encoding
  assign pteValid = valid && !(writable && !readable);

  // Any of R, W or X makes the entry a leaf, otherwise it points down a level
  assign pteLeaf = executable | writable | readable;

  // Accessed must be set, and a store also needs dirty
  assign accessAlert = !accessed || (walkIsStore && !dirty);

  // A superpage has to start on its own size, so its low PPN slices are zero
  always_comb begin
    case (level)
      2'd2:    misaligned = |curPpn[17:0];
      2'd1:    misaligned = |curPpn[8:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign pteBad = misaligned || accessAlert;

endmodule

`default_nettype wire

/* logic/ptwPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sv39 page table walker shared definitions
// Holds the RV64 and Sv39 field widths, the walker state encoding and
// the page size code that goes to the TLBs with each new entry
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ptwPkg;

  // Data path and virtual address width of the core
  localparam int xlen = 64;

  // Physical page number carried in bits 53:10 of a PTE
  localparam int ppnBits = 44;

  // Each of the three VPN slices indexes a 512-entry table
  localparam int vpnBits = 9;

  // PTEs are eight bytes, so table offsets shift by three
  localparam int pteBytesLog = 3;

  localparam int pageOffsetBits = 12;

  // Walker states, one wait and one judgement state per level
  typedef enum logic [3:0] {
    stIdle,
    stLevel2Wait,
    stLevel2,
    stLevel1Wait,
    stLevel1,
    stLevel0Wait,
    stLevel0,
    stLeaf,
    stFault
  } walkState_t;

  // Page size reported with a TLB write
  typedef enum logic [1:0] {
    pageKilo = 2'd0,
    pageMega = 2'd1,
    pageGiga = 2'd2
  } pageType_t;

  // Table level, 2 is the root and 0 the last
  typedef logic [1:0] level_t;

endpackage

`default_nettype wire

/* logic/walkerFsm.sv */
////////////////////////////////////////////////////////////////////////////
// Page table walk state machine
// Steps through the three Sv39 levels, waits out memory stalls and
// raises the registered TLB write, page fault and stall outputs
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module walkerFsm (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     walkReq,
  input  logic                     walkIsData,
  input  logic                     walkIsStore,
  input  logic                     pteValid,
  input  logic                     pteLeaf,
  input  logic                     pteBad,
  input  logic [ptwPkg::xlen-1:0]  pageTableEntryIn,
  input  logic                     memStall,
  output logic                     walkStart,
  output logic                     pteEn,
  output logic                     memRead,
  output logic                     useRoot,
  output ptwPkg::level_t           level,
  output logic [ptwPkg::xlen-1:0]  pageTableEntry,
  output ptwPkg::pageType_t        pageType,
  output logic                     itlbWrite,
  output logic                     dtlbWrite,
  output logic                     instrPageFault,
  output logic                     loadPageFault,
  output logic                     storePageFault,
  output logic                     mmuStall
);

  ptwPkg::walkState_t state, nextState;
  ptwPkg::pageType_t  leafType;
  logic               goodLeaf;
  logic               descend;

  assign walkStart = (state == ptwPkg::stIdle) && walkReq;

  // The PTE is captured on the edge that ends a wait without a stall
  assign pteEn = memRead && !memStall;

  // Judgement of the PTE captured for the current level
  assign goodLeaf = pteValid && pteLeaf && !pteBad;
  assign descend  = pteValid && !pteLeaf;

  ////////////////////////////////////////////////////////////////////////////
  // Level decode and memory request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    memRead  = 1'b0;
    level    = 2'd2;
    useRoot  = 1'b1;
    leafType = ptwPkg::pageGiga;
    case (state)
      ptwPkg::stLevel2Wait: memRead = 1'b1;
      ptwPkg::stLevel1Wait: begin
        memRead = 1'b1;
        level   = 2'd1;
        useRoot = 1'b0;
      end
      ptwPkg::stLevel1: begin
        level    = 2'd1;
        useRoot  = 1'b0;
        leafType = ptwPkg::pageMega;
      end
      ptwPkg::stLevel0Wait: begin
        memRead = 1'b1;
        level   = 2'd0;
        useRoot = 1'b0;
      end
      ptwPkg::stLevel0: begin
        level    = 2'd0;
        useRoot  = 1'b0;
        leafType = ptwPkg::pageKilo;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      ptwPkg::stIdle:
        if (walkReq) nextState = ptwPkg::stLevel2Wait;
      // Each wait state holds for as long as memory stalls
      ptwPkg::stLevel2Wait:
        if (!memStall) nextState = ptwPkg::stLevel2;
      ptwPkg::stLevel1Wait:
        if (!memStall) nextState = ptwPkg::stLevel1;
      ptwPkg::stLevel0Wait:
        if (!memStall) nextState = ptwPkg::stLevel0;
      ptwPkg::stLevel2: begin
        if (goodLeaf) nextState = ptwPkg::stLeaf;
        else if (descend) nextState = ptwPkg::stLevel1Wait;
        else nextState = ptwPkg::stFault;
      end
      ptwPkg::stLevel1: begin
        if (goodLeaf) nextState = ptwPkg::stLeaf;
        else if (descend) nextState = ptwPkg::stLevel0Wait;
        else nextState = ptwPkg::stFault;
      end
      // No level below 0, so a pointer here is a fault as well
      ptwPkg::stLevel0:
        nextState = goodLeaf ? ptwPkg::stLeaf : ptwPkg::stFault;
      default: nextState = ptwPkg::stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= ptwPkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered results, high in the cycle the machine sits in leaf or fault
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pageTableEntry <= '0;
      pageType       <= ptwPkg::pageKilo;
      itlbWrite      <= 1'b0;
      dtlbWrite      <= 1'b0;
      instrPageFault <= 1'b0;
      loadPageFault  <= 1'b0;
      storePageFault <= 1'b0;
      mmuStall       <= 1'b0;
    end else begin
      pageTableEntry <= (nextState == ptwPkg::stLeaf) ? pageTableEntryIn : '0;
      pageType       <= (nextState == ptwPkg::stLeaf) ? leafType : ptwPkg::pageKilo;
      itlbWrite      <= (nextState == ptwPkg::stLeaf) && !walkIsData;
      dtlbWrite      <= (nextState == ptwPkg::stLeaf) && walkIsData;
      instrPageFault <= (nextState == ptwPkg::stFault) && !walkIsData;
      loadPageFault  <= (nextState == ptwPkg::stFault) && walkIsData && !walkIsStore;
      storePageFault <= (nextState == ptwPkg::stFault) && walkIsData && walkIsStore;
      // Stall drops early on a fault so the core can take the trap
      mmuStall       <= (nextState != ptwPkg::stIdle) && (nextState != ptwPkg::stFault);
    end
  end

  // A walk ends either in a TLB write or in a fault, never both
  strobeOrFault: assert property (@(posedge clk) disable iff (!rstN)
    !((itlbWrite || dtlbWrite) && (instrPageFault || loadPageFault || storePageFault)));

  // A stalled read stays requested until memory answers
  readHeldInStall: assert property (@(posedge clk) disable iff (!rstN)
    (memRead && memStall) |=> memRead);

endmodule

`default_nettype wire

/* pageTableWalker.f */
logic/ptwPkg.sv
logic/missArbiter.sv
logic/walkerFsm.sv
logic/pteDecode.sv
logic/ptAddrGen.sv
logic/pageTableWalker.sv
sim/tbPageTableWalker.sv

/* sim/tbPageTableWalker.sv */
////////////////////////////////////////////////////////////////////////////
// Sv39 page table walker testbench
// Models the page table memory with random stalls and walks it with a
// reference walk. It checks every TLB write and page fault the walker
// raises, along with the stall and read request levels around them
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module tbPageTableWalker;

  localparam int paBits = 56;
  localparam int resetCycles = 16;
  localparam int quietCycles = 10;
  localparam int maxStall = 3;
  localparam int numWalks = 44;
  // Every level costs a wait, its stalls and a judgement, plus a few idle cycles
  localparam int cycleLimit = resetCycles + quietCycles
                              + numWalks * (3 * (2 + maxStall) + 4) + 50;

  localparam logic [63:0] satpValue = {4'h8, 16'h0, 44'h80000};
  localparam logic [43:0] rootPpn = 44'h80000;
  localparam logic [43:0] midPpn = 44'h80001;
  localparam logic [43:0] lastPpn = 44'h80002;

  // PTE flag bits
  localparam logic [7:0] pteV = 8'h01;
  localparam logic [7:0] pteR = 8'h02;
  localparam logic [7:0] pteW = 8'h04;
  localparam logic [7:0] pteX = 8'h08;
  localparam logic [7:0] pteA = 8'h40;
  localparam logic [7:0] pteD = 8'h80;

  typedef enum logic [2:0] {
    resItlbWrite, resDtlbWrite, resInstrFault, resLoadFault, resStoreFault, resNone
  } resultKind_t;

  logic                    clk;
  logic                    rstN;
  logic [63:0]             satp;
  logic                    itlbMiss;
  logic [63:0]             pc;
  logic                    dtlbMiss;
  logic [63:0]             memAdr;
  logic                    memStore;
  logic [63:0]             memPte = '0;
  logic                    memStall = 1'b0;
  logic [paBits-1:0]       memPAdr;
  logic                    memRead;
  logic [63:0]             pageTableEntry;
  ptwPkg::pageType_t       pageType;
  logic                    itlbWrite;
  logic                    dtlbWrite;
  logic                    instrPageFault;
  logic                    loadPageFault;
  logic                    storePageFault;
  logic                    mmuStall;
  logic [4:0]              resultLines;
  logic                    anyResult;

  // Unwritten entries of the page table memory read as zero and so are invalid
  logic [63:0]             mem [logic [paBits-1:0]];
  logic [31:0]             stallRng = 32'h8d3b_369f;
  int                      stallRun = 0;
  int                      cycleCount = 0;
  int                      valueErrors = 0;
  int                      otherErrors = 0;
  int                      walksChecked = 0;

  // Expected results in the order the walker must serve them
  resultKind_t             expKindQ[$];
  logic [63:0]             expPteQ[$];
  ptwPkg::pageType_t       expTypeQ[$];
  string                   labelQ[$];

  pageTableWalker #(.paBits(paBits)) DUT (
    .clk(clk), .rstN(rstN), .satp(satp), .itlbMiss(itlbMiss), .pc(pc),
    .dtlbMiss(dtlbMiss), .memAdr(memAdr), .memStore(memStore), .memPte(memPte),
    .memStall(memStall), .memPAdr(memPAdr), .memRead(memRead),
    .pageTableEntry(pageTableEntry), .pageType(pageType), .itlbWrite(itlbWrite),
    .dtlbWrite(dtlbWrite), .instrPageFault(instrPageFault),
    .loadPageFault(loadPageFault), .storePageFault(storePageFault), .mmuStall(mmuStall)
  );

  assign resultLines = {itlbWrite, dtlbWrite, instrPageFault, loadPageFault, storePageFault};
  assign anyResult = |resultLines;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [63:0] readTable(input logic [paBits-1:0] adr);
    return mem.exists(adr) ? mem[adr] : 64'd0;
  endfunction

  function automatic logic [63:0] makePte(input logic [43:0] ppn, input logic [7:0] flags);
    return {10'd0, ppn, 2'd0, flags};
  endfunction

  function automatic logic [63:0] makeVa(input logic [8:0] v2, input logic [8:0] v1,
                                         input logic [8:0] v0, input logic [11:0] off);
    return {25'd0, v2, v1, v0, off};
  endfunction

  task automatic writeEntry(input logic [43:0] tablePpn, input logic [8:0] idx,
                            input logic [63:0] entry);
    mem[{tablePpn, idx, 3'b000}] = entry;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference walk
  ////////////////////////////////////////////////////////////////////////////

  function automatic resultKind_t faultKind(input logic isData, input logic isStore);
    if (!isData) return resInstrFault;
    return isStore ? resStoreFault : resLoadFault;
  endfunction

  // Walks the table by the Sv39 rules and returns a zero PTE and kilo type on a fault
  function automatic resultKind_t refWalk(input logic [63:0] va, input logic isData,
                                          input logic isStore, output logic [63:0] expPte,
                                          output ptwPkg::pageType_t expType);
    logic [43:0]       ppn;
    logic [63:0]       entry;
    logic [8:0]        vpnSlice;
    logic [paBits-1:0] adr;
    logic              store;
    int                lvl;
    ppn = satpValue[43:0];
    expPte = '0;
    expType = ptwPkg::pageKilo;
    // An instruction fetch never counts as a store
    store = isData && isStore;
    for (lvl = 2; lvl >= 0; lvl--) begin
      vpnSlice = va[12 + 9 * lvl +: 9];
      adr = {ppn, vpnSlice, 3'b000};
      entry = readTable(adr);
      if (!entry[0] || (entry[2] && !entry[1])) return faultKind(isData, store);
      if (entry[3:1] != 3'd0) begin
        // Superpages must be aligned to their own size
        if (lvl == 2 && entry[27:10] != 18'd0) return faultKind(isData, store);
        if (lvl == 1 && entry[18:10] != 9'd0) return faultKind(isData, store);
        if (!entry[6] || (store && !entry[7])) return faultKind(isData, store);
        expPte = entry;
        expType = (lvl == 2) ? ptwPkg::pageGiga :
                  (lvl == 1) ? ptwPkg::pageMega : ptwPkg::pageKilo;
        return isData ? resDtlbWrite : resItlbWrite;
      end
      ppn = entry[53:10];
    end
    // A pointer at level 0 has nowhere to go
    return faultKind(isData, store);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkPte(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL @ %0t: %s PTE is %h, expected %h", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  task automatic checkPageType(input ptwPkg::pageType_t got, input ptwPkg::pageType_t exp,
                               input string what);
    if (got !== exp) begin
      $display("FAIL @ %0t: %s page type is %s, expected %s", $time, what,
               got.name(), exp.name());
      valueErrors++;
    end
  endtask

  task automatic checkKind(input resultKind_t got, input resultKind_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL @ %0t: %s result is %s, expected %s", $time, what,
               got.name(), exp.name());
      valueErrors++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    otherErrors++;
  endtask

  function automatic resultKind_t observedKind();
    if (itlbWrite) return resItlbWrite;
    if (dtlbWrite) return resDtlbWrite;
    if (instrPageFault) return resInstrFault;
    if (loadPageFault) return resLoadFault;
    if (storePageFault) return resStoreFault;
    return resNone;
  endfunction

  // Memory answers each read after a random number of stall cycles
  always @(negedge clk) begin
    stallRng = xorshift32(stallRng);
    if (rstN && memRead && stallRun < maxStall && stallRng[4]) begin
      memStall = 1'b1;
      stallRun++;
      // Data on a stalled cycle is junk and must never be taken
      memPte = {stallRng, ~stallRng};
    end else begin
      memStall = 1'b0;
      stallRun = 0;
      memPte = (rstN && memRead) ? readTable(memPAdr) : 64'd0;
    end
  end

  // Results are registered, so they are steady at the falling edge
  always @(negedge clk) begin : compareResults
    resultKind_t       expKind;
    logic [63:0]       expPte;
    ptwPkg::pageType_t expType;
    string             label;
    if (rstN && anyResult) begin
      if ($countones(resultLines) != 1) begin
        reportFailure("more than one result line high in the same cycle");
      end
      if (expKindQ.size() == 0) begin
        reportFailure("a walk result appeared with no walk pending");
      end else begin
        expKind = expKindQ.pop_front();
        expPte = expPteQ.pop_front();
        expType = expTypeQ.pop_front();
        label = labelQ.pop_front();
        checkKind(observedKind(), expKind, label);
        checkPte(pageTableEntry, expPte, label);
        checkPageType(pageType, expType, label);
        walksChecked++;
      end
      if ((instrPageFault || loadPageFault || storePageFault) && mmuStall) begin
        reportFailure("mmuStall stayed high during a page fault pulse");
      end
      if ((itlbWrite || dtlbWrite) && !mmuStall) begin
        reportFailure("mmuStall was low during a TLB write");
      end
    end else if (rstN) begin
      // Leaf outputs are zero outside the write cycle
      checkPte(pageTableEntry, 64'd0, "no result cycle");
      checkPageType(pageType, ptwPkg::pageKilo, "no result cycle");
    end
  end

  // Ends the run once the walks have taken longer than their worst case
  initial begin : watchdog
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the walks did not all finish", cycleCount);
    $display("Summary: %0d value errors, %0d other errors, %0d walks checked",
             valueErrors, otherErrors, walksChecked);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic buildTables();
    // Root table
    writeEntry(rootPpn, 9'd1, makePte(midPpn, pteV));
    writeEntry(rootPpn, 9'd2, makePte(44'h40000, pteV | pteR | pteW | pteX | pteA | pteD));
    writeEntry(rootPpn, 9'd3, makePte(44'h40200, pteV | pteR | pteW | pteA | pteD));
    writeEntry(rootPpn, 9'd4, makePte(44'h50000, pteR | pteW | pteA | pteD));
    writeEntry(rootPpn, 9'd5, makePte(44'h60000, pteV | pteW | pteA | pteD));
    // Level 1 table
    writeEntry(midPpn, 9'd0, makePte(lastPpn, pteV));
    writeEntry(midPpn, 9'd1, makePte(44'h1200, pteV | pteR | pteW | pteX | pteA | pteD));
    writeEntry(midPpn, 9'd2, makePte(44'h1201, pteV | pteR | pteX | pteA | pteD));
    // Level 0 table
    writeEntry(lastPpn, 9'd0, makePte(44'h12345, pteV | pteR | pteW | pteX | pteA | pteD));
    writeEntry(lastPpn, 9'd1, makePte(44'h23456, pteV | pteR | pteW));
    writeEntry(lastPpn, 9'd2, makePte(44'h34567, pteV | pteR | pteW | pteA));
    writeEntry(lastPpn, 9'd3, makePte(44'h80003, pteV));
    writeEntry(lastPpn, 9'd4, makePte(44'h00777, pteV | pteX | pteA));
  endtask

  task automatic queueExpected(input logic isData, input logic isStore, input logic [63:0] va,
                               input string label);
    logic [63:0]       expPte;
    ptwPkg::pageType_t expType;
    resultKind_t       expKind;
    expKind = refWalk(va, isData, isStore, expPte, expType);
    expKindQ.push_back(expKind);
    expPteQ.push_back(expPte);
    expTypeQ.push_back(expType);
    labelQ.push_back(label);
  endtask

  // Holds at falling edges until a result shows and checks that the core stays stalled
  task automatic waitResult();
    while (!anyResult) begin
      if (!mmuStall) reportFailure("mmuStall was low while a walk was running");
      @(negedge clk);
    end
  endtask

  task automatic runWalk(input logic isData, input logic isStore, input logic [63:0] va,
                         input string label);
    @(negedge clk);
    queueExpected(isData, isStore, va, label);
    if (isData) begin
      dtlbMiss = 1'b1;
      memAdr = va;
    end else begin
      itlbMiss = 1'b1;
      pc = va;
    end
    memStore = isStore;
    @(negedge clk);
    // The walk has started, so changing the live request must not disturb it
    pc = ~va;
    memAdr = ~va;
    memStore = ~isStore;
    waitResult();
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
  endtask

  // With both misses raised at once the data side has to go first
  task automatic runPair(input logic [63:0] dataVa, input logic isStore,
                         input logic [63:0] instrVa);
    @(negedge clk);
    queueExpected(1'b1, isStore, dataVa, "simultaneous data walk");
    queueExpected(1'b0, 1'b0, instrVa, "simultaneous instruction walk");
    dtlbMiss = 1'b1;
    memAdr = dataVa;
    memStore = isStore;
    itlbMiss = 1'b1;
    pc = instrVa;
    @(negedge clk);
    waitResult();
    dtlbMiss = 1'b0;
    // One idle cycle starts the instruction walk before the stall is checked again
    repeat (2) @(negedge clk);
    waitResult();
    itlbMiss = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] walkRng;
    logic [63:0] va;
    int          i;
    rstN = 1'b0;
    satp = satpValue;
    itlbMiss = 1'b0;
    pc = '0;
    dtlbMiss = 1'b0;
    memAdr = '0;
    memStore = 1'b0;
    walkRng = 32'h8d3b_369f;
    buildTables();
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;

    // Nothing may move without a miss
    repeat (quietCycles) begin
      @(negedge clk);
      if ({mmuStall, memRead, resultLines} !== 7'd0) begin
        reportFailure("an output went high after reset with no miss pending");
      end
    end

    // Leaves of all three sizes
    runWalk(1'b0, 1'b0, makeVa(9'd1, 9'd0, 9'd0, 12'h010), "instruction 4 KiB");
    runWalk(1'b1, 1'b0, makeVa(9'd1, 9'd0, 9'd0, 12'h123), "data load 4 KiB");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd0, 9'd0, 12'h456), "data store 4 KiB");
    runWalk(1'b0, 1'b0, makeVa(9'd1, 9'd1, 9'd7, 12'h020), "instruction mega");
    runWalk(1'b1, 1'b0, makeVa(9'd1, 9'd1, 9'd9, 12'h030), "data load mega");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd1, 9'd3, 12'h040), "data store mega");
    runWalk(1'b0, 1'b0, makeVa(9'd2, 9'd5, 9'd6, 12'h050), "instruction giga");
    runWalk(1'b1, 1'b1, makeVa(9'd2, 9'd8, 9'd1, 12'h060), "data store giga");
    runPair(makeVa(9'd1, 9'd1, 9'd2, 12'h070), 1'b0, makeVa(9'd2, 9'd3, 9'd4, 12'h080));

    // Invalid, reserved, misaligned and dead end entries
    runWalk(1'b0, 1'b0, makeVa(9'd4, 9'd0, 9'd0, 12'h000), "instruction invalid");
    runWalk(1'b1, 1'b0, makeVa(9'd4, 9'd0, 9'd0, 12'h000), "load invalid");
    runWalk(1'b1, 1'b1, makeVa(9'd4, 9'd0, 9'd0, 12'h000), "store invalid");
    runWalk(1'b0, 1'b0, makeVa(9'd5, 9'd0, 9'd0, 12'h000), "instruction W without R");
    runWalk(1'b1, 1'b0, makeVa(9'd5, 9'd0, 9'd0, 12'h000), "load W without R");
    runWalk(1'b1, 1'b1, makeVa(9'd5, 9'd0, 9'd0, 12'h000), "store W without R");
    runWalk(1'b1, 1'b0, makeVa(9'd3, 9'd0, 9'd0, 12'h000), "load misaligned giga");
    runWalk(1'b0, 1'b0, makeVa(9'd1, 9'd2, 9'd0, 12'h000), "instruction misaligned mega");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd2, 9'd0, 12'h000), "store misaligned mega");
    runWalk(1'b0, 1'b0, makeVa(9'd1, 9'd0, 9'd3, 12'h000), "instruction pointer at level 0");
    runWalk(1'b1, 1'b0, makeVa(9'd1, 9'd0, 9'd3, 12'h000), "load pointer at level 0");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd0, 9'd3, 12'h000), "store pointer at level 0");

    // Accessed and dirty alerts
    runWalk(1'b1, 1'b0, makeVa(9'd1, 9'd0, 9'd1, 12'h000), "load with A clear");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd0, 9'd1, 12'h000), "store with A clear");
    runWalk(1'b1, 1'b1, makeVa(9'd1, 9'd0, 9'd2, 12'h000), "store with D clear");
    runWalk(1'b1, 1'b0, makeVa(9'd1, 9'd0, 9'd2, 12'h000), "load with D clear");
    runWalk(1'b0, 1'b1, makeVa(9'd1, 9'd0, 9'd2, 12'h000), "instruction with D clear");
    runWalk(1'b0, 1'b0, makeVa(9'd1, 9'd0, 9'd4, 12'h000), "instruction execute only");

    // Random walks over the populated corner of the tables
    for (i = 0; i < 16; i++) begin
      walkRng = xorshift32(walkRng);
      va = makeVa(9'(walkRng[2:0] % 3'd6), 9'(walkRng[5:4] % 2'd3),
                  9'(walkRng[10:8] % 3'd5), walkRng[27:16]);
      runWalk(walkRng[12], walkRng[13], va, "random walk");
    end

    repeat (4) @(negedge clk);
    if (expKindQ.size() != 0) reportFailure("some walks never returned a result");
    $display("Summary: %0d value errors, %0d other errors, %0d walks checked",
             valueErrors, otherErrors, walksChecked);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
